//--- common/arrayIsaPkg.sv
// Instruction set of the array machine
// Opcodes, instruction field layout and program memory geometry

package arrayIsaPkg;

  localparam int NProgram     = 256;                  // Program words
  localparam int OpWidth      = 4;
  localparam int TargetWidth  = 12;
  localparam int OperandWidth = 10;
  localparam int InstrWidth   = OpWidth + TargetWidth + 2 * OperandWidth;

  // Bit positions inside the instruction word
  localparam int OpLsb     = TargetWidth + 2 * OperandWidth;
  localparam int TargetLsb = 2 * OperandWidth;
  localparam int ALsb      = OperandWidth;
  localparam int BLsb      = 0;

  typedef logic [7:0]              progAddr_t;        // Program address
  typedef logic [InstrWidth-1:0]   instr_t;           // op | target | a | b
  typedef logic [TargetWidth-1:0]  target_t;          // Local address or jump address
  typedef logic [OperandWidth-1:0] operand_t;         // Local address or immediate

  typedef enum logic [OpWidth-1:0]
  {
    opNop,
    opMovImm,                                         // target = b
    opMov,                                            // target = [a]
    opAdd,                                            // target = [a] + [b]
    opArray,                                          // target = new handle
    opFree,                                           // Release handle [a]
    opHeapWrite,                                      // heap[[a]][[target]] = b
    opHeapRead,                                       // target = heap[[a]][[b]]
    opResize,                                         // size[[a]] = [b]
    opShiftUp,                                        // Insert b at index 0 of [a]
    opArraySize,                                      // target = size[[a]]
    opJge,                                            // Jump if [a] >= [b]
    opJmp,
    opOut,                                            // Emit [a]
    opHalt
  } opcode_t;

endpackage

//--- common/arrayMemPkg.sv
// Memory geometry of the array machine
// Word width, local and heap sizes, address and handle types

package arrayMemPkg;

  localparam int WordWidth = 12;
  localparam int NLocal    = 64;                      // Local scalar words
  localparam int NArrays   = 8;                       // Array handles
  localparam int NArea     = 10;                      // Words per array area
  localparam int NHeap     = NArrays * NArea;

  typedef logic [WordWidth-1:0]           word_t;
  typedef logic [$clog2(NLocal)-1:0]      localAddr_t;
  typedef logic [$clog2(NArrays)-1:0]     handle_t;
  typedef logic [$clog2(NArrays+1)-1:0]   handleCount_t; // 0 up to NArrays inclusive
  typedef logic [$clog2(NHeap)-1:0]       heapAddr_t;
  typedef logic [$clog2(NArea)-1:0]       areaIndex_t;   // Position inside one area

endpackage

//--- common/stageIf.sv
// Pipeline link between two stages
// One instruction forward, stall and flush back, with modports
`timescale 1ns/1ps

interface stageIf;
  import arrayIsaPkg::*;

  logic      valid;
  progAddr_t ip;
  instr_t    instr;
  opcode_t   op;
  target_t   target;
  operand_t  a;
  operand_t  b;
  logic      isJump;
  logic      isMulti;
  logic      stall;                                   // Level, hold everything upstream
  logic      flush;                                   // Pulse on taken jump or start
  progAddr_t flushIp;                                 // Where fetch resumes after flush

  modport source (output valid, ip, instr, op, target, a, b, isJump, isMulti,
                  input  stall, flush, flushIp);
  modport sink   (input  valid, ip, instr, op, target, a, b, isJump, isMulti,
                  output stall, flush, flushIp);
  modport monitor(input  valid, ip, instr, op, target, a, b, isJump, isMulti,
                         stall, flush, flushIp);

endinterface

//--- rtl/fetchStage.sv
// Fetch stage
// Program memory with load port, instruction pointer and fetch register
`timescale 1ns/1ps

module fetchStage
(
  input  logic                 run,
  input  logic                 reset,
  input  logic                 loadEnable,
  input  arrayIsaPkg::progAddr_t loadAddress,
  input  arrayIsaPkg::instr_t  loadData,
  input  logic                 start,
  input  logic                 halt,
  stageIf.source               out
);
  import arrayIsaPkg::*;

  instr_t    progMem [NProgram];
  progAddr_t ip;
  logic      running;
  logic      advance;

  assign advance = running && !halt && !out.flush && !out.stall;

  always_ff @(posedge run)
  begin
    if (loadEnable)
      progMem[loadAddress] <= loadData;
  end

  always_ff @(posedge run)
  begin
    if (reset)
    begin
      running   <= 1'b0;
      ip        <= '0;
      out.valid <= 1'b0;
    end
    else if (start)
    begin
      running   <= 1'b1;
      ip        <= '0;
      out.valid <= 1'b0;
    end
    else if (halt)
    begin
      running   <= 1'b0;                              // Halt or fault stops fetch
      out.valid <= 1'b0;
    end
    else if (out.flush)
    begin
      ip        <= out.flushIp;                       // Redirect, drop the fetched word
      out.valid <= 1'b0;
    end
    else if (advance)
    begin
      ip        <= ip + 1'b1;
      out.valid <= 1'b1;
    end
  end

  always_ff @(posedge run)
  begin
    if (advance)
    begin
      out.ip    <= ip;
      out.instr <= progMem[ip];
    end
  end

  // Fields are split out one stage later
  assign out.op      = opNop;
  assign out.target  = '0;
  assign out.a       = '0;
  assign out.b       = '0;
  assign out.isJump  = 1'b0;
  assign out.isMulti = 1'b0;

  loadWhileIdle: assert property (@(posedge run) disable iff (reset)
    loadEnable |-> !running);

endmodule

//--- rtl/decodeStage.sv
// Decode stage
// Field split, jump and multi-cycle marking, no-op removal
`timescale 1ns/1ps

module decodeStage
(
  input  logic   run,
  input  logic   reset,
  stageIf.sink   in,
  stageIf.source out
);
  import arrayIsaPkg::*;

  opcode_t opcode;
  logic    take;

  assign opcode = opcode_t'(in.instr[OpLsb +: OpWidth]);
  assign take   = in.valid && !out.stall;

  // Stall and flush come from execute and go straight on to fetch
  assign in.stall   = out.stall;
  assign in.flush   = out.flush;
  assign in.flushIp = out.flushIp;

  always_ff @(posedge run)
  begin
    if (reset)
      out.valid <= 1'b0;
    else if (out.flush)
      out.valid <= 1'b0;                              // Wrong path
    else if (!out.stall)
      out.valid <= in.valid && opcode != opNop;       // No-ops never reach execute
  end

  always_ff @(posedge run)
  begin
    if (take)
    begin
      out.ip      <= in.ip;
      out.instr   <= in.instr;
      out.op      <= opcode;
      out.target  <= in.instr[TargetLsb +: TargetWidth];
      out.a       <= in.instr[ALsb +: OperandWidth];
      out.b       <= in.instr[BLsb +: OperandWidth];
      out.isJump  <= opcode == opJge || opcode == opJmp;
      out.isMulti <= opcode == opShiftUp;
    end
  end

endmodule

//--- execute/heapUnit.sv
// Heap unit
// Array allocation with free stack, size table, heap read and write,
// and the shift-up sequencer
`timescale 1ns/1ps

module heapUnit
(
  input  logic                  run,
  input  logic                  reset,
  input  logic                  start,
  input  arrayIsaPkg::opcode_t  op,
  input  logic                  strobe,
  input  arrayMemPkg::handle_t  handle,
  input  arrayMemPkg::word_t    index,
  input  arrayMemPkg::word_t    value,
  output arrayMemPkg::word_t    readValue,
  output arrayMemPkg::handle_t  newHandle,
  output logic                  busy,
  output logic                  error
);
  import arrayIsaPkg::*;
  import arrayMemPkg::*;

  typedef enum logic [1:0] {shiftIdle, shiftMove, shiftInsert, shiftGrow} shiftState_t;

  word_t        heapMem [NHeap];
  word_t        sizes   [NArrays];
  handle_t      freed   [NArrays];                    // Stack of released handles
  handleCount_t freeTop;
  handleCount_t allocs;                               // Fresh handles handed out so far
  shiftState_t  state;
  areaIndex_t   step;
  heapAddr_t    base;
  heapAddr_t    addr;
  heapAddr_t    shiftBase;
  handle_t      shiftHandle;
  word_t        shiftValue;
  logic         noHandle;
  logic         outOfArea;

  assign base = heapAddr_t'(handle) * heapAddr_t'(NArea);
  assign addr = base + heapAddr_t'(index);

  assign noHandle  = freeTop == '0 && allocs == handleCount_t'(NArrays);
  assign newHandle = freeTop != '0 ? freed[handle_t'(freeTop - 1'b1)] : handle_t'(allocs);
  assign outOfArea = (op inside {opHeapWrite, opHeapRead} && index >= word_t'(NArea))
                  || (op == opResize && value > word_t'(NArea));
  assign error     = strobe && ((op == opArray && noHandle) || outOfArea);

  assign readValue = op == opArraySize ? sizes[handle] : heapMem[addr];
  assign busy      = state != shiftIdle;

  // ------------------------------------------------------------------------
  // Handle bookkeeping and shift sequencer
  // ------------------------------------------------------------------------
  always_ff @(posedge run)
  begin
    if (reset || start)
    begin
      freeTop <= '0;
      allocs  <= '0;
      state   <= shiftIdle;
      step    <= '0;
    end
    else
    begin
      if (strobe && !error)
        case (op)
          opArray:
            if (freeTop != '0)
              freeTop <= freeTop - 1'b1;              // Reuse most recently freed
            else
              allocs <= allocs + 1'b1;
          opFree:
            freeTop <= freeTop + 1'b1;
          opShiftUp:
          begin
            state <= shiftMove;
            step  <= areaIndex_t'(NArea - 1);         // Start at the top word
          end
          default: ;
        endcase
      case (state)
        shiftMove:
          if (step == areaIndex_t'(1))
            state <= shiftInsert;
          else
            step <= step - 1'b1;
        shiftInsert: state <= shiftGrow;
        shiftGrow:   state <= shiftIdle;
        default: ;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // Memories
  // ------------------------------------------------------------------------
  always_ff @(posedge run)
  begin
    if (strobe && op == opShiftUp)
    begin
      shiftBase   <= base;
      shiftHandle <= handle;
      shiftValue  <= value;
    end
    if (strobe && op == opFree)
      freed[handle_t'(freeTop)] <= handle;
  end

  always_ff @(posedge run)
  begin
    if (strobe && op == opHeapWrite && !error)
      heapMem[addr] <= value;
    else if (state == shiftMove)
      heapMem[shiftBase + heapAddr_t'(step)] <= heapMem[shiftBase + heapAddr_t'(step) - 1'b1];
    else if (state == shiftInsert)
      heapMem[shiftBase] <= shiftValue;               // New word goes in at index 0
  end

  always_ff @(posedge run)
  begin
    if (strobe && op == opArray && !error)
      sizes[newHandle] <= '0;
    else if (strobe && op == opResize && !error)
      sizes[handle] <= value;
    else if (state == shiftGrow)
      sizes[shiftHandle] <= sizes[shiftHandle] + 1'b1;
  end

  // Free stack depth stays within the handle count
  freeStackBound: assert property (@(posedge run) disable iff (reset)
    strobe && op == opFree |-> freeTop < handleCount_t'(NArrays));

endmodule

//--- execute/executeStage.sv
// Execute stage
// Local memory, scalar ops, jumps, output channel, halt and fault
// Array operations are handed to the heap unit
`timescale 1ns/1ps

module executeStage
(
  input  logic               run,
  input  logic               reset,
  input  logic               start,
  stageIf.sink               in,
  output logic               halt,
  output logic               outValid,
  output arrayMemPkg::word_t outValue,
  output logic               finished,
  output logic               fault
);
  import arrayIsaPkg::*;
  import arrayMemPkg::*;

  word_t      localMem [NLocal];
  localAddr_t tAddr;
  localAddr_t aAddr;
  localAddr_t bAddr;
  word_t      tVal;
  word_t      aVal;
  word_t      bVal;
  word_t      immVal;
  word_t      result;
  logic       exec;
  logic       writesLocal;
  logic       taken;

  // Heap unit connection
  logic       heapStrobe;
  logic       heapBusy;
  logic       heapError;
  word_t      heapIndex;
  word_t      heapValue;
  word_t      heapRead;
  handle_t    newHandle;

  // ------------------------------------------------------------------------
  // Operand read, straight from local memory
  // ------------------------------------------------------------------------
  assign tAddr  = localAddr_t'(in.target);
  assign aAddr  = localAddr_t'(in.a);
  assign bAddr  = localAddr_t'(in.b);
  assign tVal   = localMem[tAddr];
  assign aVal   = localMem[aAddr];
  assign bVal   = localMem[bAddr];
  assign immVal = word_t'(in.b);                      // Zero extended immediate

  assign exec = in.valid && !heapBusy && !finished;

  // Hold upstream while the shift sequencer runs
  assign in.stall = heapBusy;

  assign taken      = exec && in.isJump && (in.op == opJmp || aVal >= bVal);
  assign in.flush   = taken || start;
  assign in.flushIp = start ? '0 : progAddr_t'(in.target);

  // ------------------------------------------------------------------------
  // Heap unit
  // ------------------------------------------------------------------------
  assign heapStrobe = exec && (in.isMulti || in.op inside
                      {opArray, opFree, opHeapWrite, opHeapRead, opResize, opArraySize});
  assign heapIndex  = in.op == opHeapWrite ? tVal : bVal;
  assign heapValue  = in.op == opResize ? bVal : immVal;

  heapUnit heapUnit_i
  (
    .run       (run),
    .reset     (reset),
    .start     (start),
    .op        (in.op),
    .strobe    (heapStrobe),
    .handle    (handle_t'(aVal)),
    .index     (heapIndex),
    .value     (heapValue),
    .readValue (heapRead),
    .newHandle (newHandle),
    .busy      (heapBusy),
    .error     (heapError)
  );

  // ------------------------------------------------------------------------
  // Result and local write back
  // ------------------------------------------------------------------------
  always_comb
  begin
    writesLocal = 1'b1;
    result      = '0;
    case (in.op)
      opMovImm:    result = immVal;
      opMov:       result = aVal;
      opAdd:       result = aVal + bVal;
      opArray:     result = word_t'(newHandle);
      opHeapRead:  result = heapRead;
      opArraySize: result = heapRead;                 // Size comes back on the same bus
      default:     writesLocal = 1'b0;
    endcase
  end

  always_ff @(posedge run)
  begin
    if (exec && writesLocal && !heapError)
      localMem[tAddr] <= result;
    if (exec && in.op == opOut)
      outValue <= aVal;
  end

  always_ff @(posedge run)
  begin
    if (reset || start)
    begin
      outValid <= 1'b0;
      finished <= 1'b0;
      fault    <= 1'b0;
    end
    else
    begin
      outValid <= exec && in.op == opOut;
      if (heapError)
      begin
        fault    <= 1'b1;                             // No handle left or index out of area
        finished <= 1'b1;
      end
      else if (exec && in.op == opHalt)
        finished <= 1'b1;
    end
  end

  assign halt = finished;

  noOutputAfterFinish: assert property (@(posedge run) disable iff (reset)
    finished |=> !outValid);

endmodule

//--- rtl/arrayMachine.sv
// Array machine top level
// Fetch, decode and execute joined by two stage links
`timescale 1ns/1ps

module arrayMachine
(
  input  logic                   run,
  input  logic                   reset,
  input  logic                   loadEnable,
  input  arrayIsaPkg::progAddr_t loadAddress,
  input  arrayIsaPkg::instr_t    loadData,
  input  logic                   start,
  output logic                   outValid,
  output arrayMemPkg::word_t     outValue,
  output logic                   finished,
  output logic                   fault
);

  logic halt;                                         // Execute stops fetch

  stageIf fetchToDecode ();
  stageIf decodeToExecute ();

  fetchStage fetchStage_i
  (
    .run         (run),
    .reset       (reset),
    .loadEnable  (loadEnable),
    .loadAddress (loadAddress),
    .loadData    (loadData),
    .start       (start),
    .halt        (halt),
    .out         (fetchToDecode.source)
  );

  decodeStage decodeStage_i
  (
    .run   (run),
    .reset (reset),
    .in    (fetchToDecode.sink),
    .out   (decodeToExecute.source)
  );

  executeStage executeStage_i
  (
    .run      (run),
    .reset    (reset),
    .start    (start),
    .in       (decodeToExecute.sink),
    .halt     (halt),
    .outValid (outValid),
    .outValue (outValue),
    .finished (finished),
    .fault    (fault)
  );

endmodule

//--- verif/arrayModel.svh
// Testbench reference model of the array machine
// Program builder tasks and the interpreter that predicts outputs and faults
`ifndef ARRAY_MODEL_SVH
`define ARRAY_MODEL_SVH

  localparam int MaxSteps = 4000;                     // Model gives up on endless loops

  task automatic clearProgram();
    progLen = 0;
    for (int i = 0; i < NProgram; i++)
      prog[i] = {opHalt, target_t'(0), operand_t'(0), operand_t'(0)};
  endtask

  task automatic addInstr(input opcode_t op, input int target, input int a, input int b);
    prog[progLen] = {op, target_t'(target), operand_t'(a), operand_t'(b)};
    progLen++;
  endtask

  // Fills in a forward jump once its label is known
  task automatic patchTarget(input int at, input int target);
    prog[at][TargetLsb +: TargetWidth] = target_t'(target);
  endtask

  function automatic void expectRun(input instr_t code [NProgram], output word_t outs [$],
                                    output logic expFault, output logic expFinished);
    word_t   loc [NLocal];
    word_t   heap [NHeap];
    word_t   sizes [NArrays];
    int      freed [NArrays];
    int      freeTop;
    int      fresh;
    int      ip;
    int      steps;
    int      t;
    int      h;
    opcode_t op;
    word_t   av;
    word_t   bv;
    word_t   tv;
    word_t   imm;
    outs        = {};
    expFault    = 1'b0;
    expFinished = 1'b0;
    freeTop     = 0;
    fresh       = 0;
    ip          = 0;
    steps       = 0;
    for (int i = 0; i < NLocal; i++)
      loc[i] = '0;
    for (int i = 0; i < NHeap; i++)
      heap[i] = '0;
    for (int i = 0; i < NArrays; i++)
      sizes[i] = '0;
    while (!expFinished && steps < MaxSteps)
    begin
      op    = opcode_t'(code[ip][OpLsb +: OpWidth]);
      t     = int'(code[ip][TargetLsb +: TargetWidth]);
      av    = loc[int'(code[ip][ALsb +: OperandWidth]) % NLocal];
      bv    = loc[int'(code[ip][BLsb +: OperandWidth]) % NLocal];
      imm   = word_t'(code[ip][BLsb +: OperandWidth]);
      tv    = loc[t % NLocal];
      h     = int'(av) % NArrays;                     // Handle is the low bits of [a]
      ip    = (ip + 1) % NProgram;
      steps = steps + 1;
      case (op)
        opMovImm:    loc[t % NLocal] = imm;
        opMov:       loc[t % NLocal] = av;
        opAdd:       loc[t % NLocal] = av + bv;
        opArray:
        begin
          if (freeTop == 0 && fresh == NArrays)
            expFault = 1'b1;                          // No handle left
          else if (freeTop > 0)
          begin
            freeTop = freeTop - 1;                    // Last freed comes back first
            sizes[freed[freeTop]] = '0;
            loc[t % NLocal] = word_t'(freed[freeTop]);
          end
          else
          begin
            sizes[fresh] = '0;
            loc[t % NLocal] = word_t'(fresh);
            fresh = fresh + 1;
          end
        end
        opFree:
        begin
          freed[freeTop] = h;
          freeTop = freeTop + 1;
        end
        opHeapWrite:
          if (tv >= NArea)
            expFault = 1'b1;
          else
            heap[h * NArea + int'(tv)] = imm;
        opHeapRead:
          if (bv >= NArea)
            expFault = 1'b1;
          else
            loc[t % NLocal] = heap[h * NArea + int'(bv)];
        opResize:
          if (bv > NArea)
            expFault = 1'b1;
          else
            sizes[h] = bv;
        opShiftUp:
        begin
          for (int k = NArea - 1; k > 0; k--)
            heap[h * NArea + k] = heap[h * NArea + k - 1];
          heap[h * NArea] = imm;
          sizes[h] = sizes[h] + 1'b1;
        end
        opArraySize: loc[t % NLocal] = sizes[h];
        opJge:
          if (av >= bv)
            ip = t % NProgram;
        opJmp:       ip = t % NProgram;
        opOut:       outs.push_back(av);
        opHalt:      expFinished = 1'b1;
        default: ;                                    // Nop
      endcase
      if (expFault)
        expFinished = 1'b1;                           // Fault ends the run
    end
  endfunction

`endif

//--- verif/arrayMachineTb.sv
// Testbench for the array machine
// Clock, reset, program stimulus, LFSR, output checks, watchdog and report
`timescale 1ns/1ps

module arrayMachineTb;
  import arrayIsaPkg::*;
  import arrayMemPkg::*;

  localparam int NRandom   = 4;
  localparam int NPrograms = 7 + NRandom;             // Runs in one simulation
  localparam int RunLimit  = 1500;                    // Cycles allowed for one run

  logic      run;
  logic      reset;
  logic      loadEnable;
  progAddr_t loadAddress;
  instr_t    loadData;
  logic      start;
  logic      outValid;
  word_t     outValue;
  logic      finished;
  logic      fault;

  instr_t      prog [NProgram];
  int          progLen;
  word_t       expected [$];                          // Words still to come from the DUT
  logic [31:0] lfsr = 32'h3490_4cff;
  int          errorCount = 0;
  int          checkCount = 0;

  `include "arrayModel.svh"

  arrayMachine arrayMachine_i
  (
    .run         (run),
    .reset       (reset),
    .loadEnable  (loadEnable),
    .loadAddress (loadAddress),
    .loadData    (loadData),
    .start       (start),
    .outValid    (outValid),
    .outValue    (outValue),
    .finished    (finished),
    .fault       (fault)
  );

  initial
  begin
    run = 1'b0;
    forever #50 run = ~run;
  end

  // --------------------------------------------------------------------------
  // Checking and random numbers
  // --------------------------------------------------------------------------
  task automatic checkValue(input string name, input int actual, input int want);
    checkCount++;
    if (actual != want)
    begin
      errorCount++;
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, actual, want);
    end
  endtask

  task automatic reportFailure(input string what);
    errorCount++;
    $display("Failure at %0t ns: %s", $time, what);
  endtask

  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return state[0] ? (state >> 1) ^ 32'h8020_0003 : state >> 1;
  endfunction

  function automatic int takeBits(input int n);
    int value;
    value = 0;
    for (int i = 0; i < n; i++)
    begin
      value = (value << 1) | int'(lfsr[0]);
      lfsr  = lfsrNext(lfsr);                         // One step per bit
    end
    return value;
  endfunction

  // Every output word is matched against the model in order
  always @(posedge run)
  begin
    if (outValid === 1'b1)
    begin
      if (expected.size() == 0)
        reportFailure($sformatf("output word %0d arrived with none expected", outValue));
      else
        checkValue("outValue", int'(outValue), int'(expected.pop_front()));
    end
  end

  initial
  begin
    repeat (NPrograms * 2000) @(posedge run);
    $display("Watchdog expired, the run did not complete");
    $display("=== FAIL ===");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Program builders
  // --------------------------------------------------------------------------
  task automatic buildReference();
    int loopAt;
    clearProgram();
    for (int i = 0; i < 4; i++)
      addInstr(opMovImm, 10 + i, 0, i);               // Index constants 0 to 3
    addInstr(opArray, 0, 0, 0);
    addInstr(opArray, 1, 0, 0);
    for (int i = 0; i < 3; i++)
      addInstr(opHeapWrite, 10 + i, 0, i);
    addInstr(opResize, 0, 0, 13);
    addInstr(opShiftUp, 0, 0, 99);
    addInstr(opArraySize, 20, 0, 0);                  // Loop limit
    addInstr(opMovImm, 21, 0, 0);                     // Loop index
    loopAt = progLen;
    addInstr(opJge, 0, 21, 20);
    addInstr(opHeapRead, 22, 0, 21);
    addInstr(opOut, 0, 22, 0);
    addInstr(opAdd, 21, 21, 11);
    addInstr(opJmp, loopAt, 0, 0);
    patchTarget(loopAt, progLen);
    addInstr(opHalt, 0, 0, 0);
  endtask

  task automatic buildLoop();
    int loopAt;
    clearProgram();
    addInstr(opMovImm, 0, 0, 3);                      // Counter
    addInstr(opMovImm, 1, 0, 2);                      // Step
    addInstr(opMovImm, 2, 0, 15);                     // Limit
    loopAt = progLen;
    addInstr(opJge, 0, 0, 2);
    addInstr(opOut, 0, 0, 0);
    addInstr(opNop, 0, 0, 0);
    addInstr(opAdd, 0, 0, 1);
    addInstr(opJmp, loopAt, 0, 0);
    addInstr(opOut, 0, 2, 0);                         // Wrong path, always flushed
    patchTarget(loopAt, progLen);
    addInstr(opHalt, 0, 0, 0);
  endtask

  task automatic buildRandom(input int count);
    int choice;
    clearProgram();
    for (int i = 0; i < 8; i++)
      addInstr(opMovImm, i, 0, takeBits(10));
    for (int i = 0; i < NArea; i++)
      addInstr(opMovImm, 10 + i, 0, i);
    addInstr(opArray, 8, 0, 0);
    for (int i = 0; i < NArea; i++)
      addInstr(opHeapWrite, 10 + i, 8, takeBits(10)); // Whole area defined
    for (int i = 0; i < count; i++)
    begin
      choice = takeBits(3) % 5;
      case (choice)
        0:       addInstr(opMovImm, takeBits(3), 0, takeBits(10));
        1:       addInstr(opAdd, takeBits(3), takeBits(3), takeBits(3));
        2:       addInstr(opHeapWrite, 10 + takeBits(4) % NArea, 8, takeBits(10));
        3:       addInstr(opHeapRead, takeBits(3), 8, 10 + takeBits(4) % NArea);
        default: addInstr(opOut, 0, takeBits(3), 0);
      endcase
    end
    addInstr(opHalt, 0, 0, 0);
  endtask

  // --------------------------------------------------------------------------
  // Running programs
  // --------------------------------------------------------------------------
  task automatic loadProgram();
    for (int i = 0; i < progLen + 2; i++)
    begin
      @(posedge run);
      loadEnable  <= 1'b1;
      loadAddress <= progAddr_t'(i);
      loadData    <= prog[i];
    end
    @(posedge run);
    loadEnable <= 1'b0;
  endtask

  task automatic pulseStart();
    @(posedge run);
    start <= 1'b1;
    @(posedge run);
    start <= 1'b0;
  endtask

  task automatic applyReset();
    reset <= 1'b1;
    repeat (3) @(posedge run);
    reset <= 1'b0;
    @(posedge run);
  endtask

  task automatic waitFinished(input string name);
    int cycles;
    cycles = 0;
    do
    begin
      @(posedge run);
      cycles++;
    end
    while (finished !== 1'b1 && cycles < RunLimit);
    if (finished !== 1'b1)
      reportFailure({name, ": finished never rose"});
  endtask

  task automatic runProgram(input string name);
    word_t words [$];
    logic  expFault;
    logic  expFinished;
    expectRun(prog, words, expFault, expFinished);
    expected = words;
    loadProgram();
    pulseStart();
    waitFinished(name);
    repeat (4) @(posedge run);                        // Room for any stray word
    checkValue({name, " words left"}, expected.size(), 0);
    checkValue({name, " fault"}, int'(fault), int'(expFault));
    checkValue({name, " finished"}, int'(finished), int'(expFinished));
    expected.delete();
  endtask

  task automatic checkReferenceModel();
    word_t words [$];
    logic  expFault;
    logic  expFinished;
    int    want [4];
    want = '{99, 0, 1, 2};
    expectRun(prog, words, expFault, expFinished);
    checkValue("model word count", words.size(), 4);
    for (int i = 0; i < 4 && i < words.size(); i++)
      checkValue("model word", int'(words[i]), want[i]);
    checkValue("model fault", int'(expFault), 0);
  endtask

  task automatic resetMidRun();
    word_t words [$];
    logic  expFault;
    logic  expFinished;
    int    cycles;
    // Still stopped by the index fault, finished and fault are high here
    applyReset();
    checkValue("finished after reset", int'(finished), 0);
    checkValue("fault after reset", int'(fault), 0);
    buildReference();
    expectRun(prog, words, expFault, expFinished);
    expected = words;
    loadProgram();
    pulseStart();
    cycles = 0;
    do
    begin
      @(posedge run);
      cycles++;
    end
    while (outValid !== 1'b1 && cycles < RunLimit);
    if (outValid !== 1'b1)
      reportFailure("no output word appeared before the reset");
    applyReset();
    checkValue("outValid after reset", int'(outValid), 0);
    expected.delete();                                // Rest of the aborted run is dropped
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial
  begin
    reset       = 1'b1;
    start       = 1'b0;
    loadEnable  = 1'b0;
    loadAddress = '0;
    loadData    = '0;
    repeat (3) @(posedge run);
    reset <= 1'b0;

    buildReference();
    checkReferenceModel();
    runProgram("reference");

    clearProgram();                                   // Allocate, free, allocate
    addInstr(opArray, 0, 0, 0);
    addInstr(opFree, 0, 0, 0);
    addInstr(opArray, 1, 0, 0);
    addInstr(opOut, 0, 0, 0);
    addInstr(opOut, 0, 1, 0);
    addInstr(opHalt, 0, 0, 0);
    runProgram("reuse");

    buildLoop();
    runProgram("loop");

    for (int i = 0; i < NRandom; i++)
    begin
      buildRandom(40);
      runProgram($sformatf("random %0d", i));
    end

    clearProgram();                                   // One array too many
    addInstr(opArray, 0, 0, 0);
    addInstr(opOut, 0, 0, 0);
    for (int i = 0; i < NArrays; i++)
      addInstr(opArray, 1, 0, 0);
    addInstr(opOut, 0, 1, 0);
    addInstr(opHalt, 0, 0, 0);
    runProgram("allocation fault");

    clearProgram();                                   // Read just past the area
    addInstr(opArray, 0, 0, 0);
    addInstr(opMovImm, 1, 0, NArea);
    addInstr(opMovImm, 2, 0, 7);
    addInstr(opOut, 0, 2, 0);
    addInstr(opHeapRead, 3, 0, 1);
    addInstr(opOut, 0, 3, 0);
    addInstr(opHalt, 0, 0, 0);
    runProgram("index fault");

    resetMidRun();
    buildReference();
    runProgram("restart");

    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- files.f
+incdir+verif
common/arrayIsaPkg.sv
common/arrayMemPkg.sv
common/stageIf.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
execute/heapUnit.sv
execute/executeStage.sv
rtl/arrayMachine.sv
verif/arrayMachineTb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile the array machine testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module arrayMachineTb \
  && ./obj_dir/VarrayMachineTb | tee /dev/stderr | grep -Fx "=== PASS ===" > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
